/* dv/sa_props.sv */
// concurrent checks on the sample_align_top ports
// bound into every sample_align_top instance
// valid history advances on enabled edges only, like the design

`timescale 1ns/1ps
`default_nettype none

`include "sa_defines.svh"

module sa_props
  import sa_pkg::*;
(
  input logic    clk,
  input logic    nrst,
  input logic    ena,
  input logic    in_valid,
  input logic    out_valid,
  input sample_t out_result,
  input tag_t    out_tag,
  input logic    out_sat
);

  // ----------------------------------------
  // accepted in_valid history
  // ----------------------------------------
  // bit 0 newest, top bit lines up with out_valid
  logic [`SA_PIPE_DEPTH:0] valid_hist;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_hist <= '0;
    end else if (ena) begin
      valid_hist <= {valid_hist[`SA_PIPE_DEPTH-1:0], in_valid};
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  reset_clears_valid: assert property (@(posedge clk) !nrst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // frozen pipeline keeps every output
  hold_when_disabled: assert property (@(posedge clk)
    (nrst && !ena) |=> ($stable(out_valid) && $stable(out_result) &&
                        $stable(out_tag) && $stable(out_sat)))
    else $error("outputs changed while ena was low");

  valid_latency: assert property (@(posedge clk) disable iff (!nrst)
    out_valid == valid_hist[`SA_PIPE_DEPTH])
    else $error("out_valid does not follow in_valid by the pipeline latency");

endmodule

bind sample_align_top sa_props i_props (.*);

`default_nettype wire

/* dv/sa_tb.sv */
// testbench for sample_align_top
// expected values come from an integer model of the scaling and merge rules
// outputs are sampled on the falling edge
// inputs change 1 ns after the rising edge
// a watchdog bounds the run time

`timescale 1ns/1ps
`default_nettype none

`include "sa_defines.svh"

module sa_tb
  import sa_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int N_ROWS     = 24;
  // rows before this index run back to back with no ena gaps
  localparam int BURST_ROWS = 6;
  localparam int LATENCY    = `SA_PIPE_DEPTH + 1;
  localparam int SMAX       = 32767;
  localparam int SMIN       = -32768;

  // one stimulus step
  // a row with ena low is driven but not accepted
  typedef struct packed {
    sample_t               sample;
    tag_t                  tag;
    op_t                   op;
    logic [`SA_GAIN_W-1:0] gain;
    sample_t               offset;
    logic                  valid;
    logic                  ena;
  } row_t;

  // expected output and the enabled edge that accepted the sample
  typedef struct {
    sample_t result;
    tag_t    tag;
    logic    sat;
    int      acc_edge;
  } exp_t;

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  localparam row_t ROWS [0:N_ROWS-1] = '{
    '{16'sd100,     8'h01, OP_SCALED, 8'd16,  16'sd0,      1'b1, 1'b1},
    '{-16'sd100,    8'h02, OP_SCALED, 8'd32,  16'sd5,      1'b1, 1'b1},
    // zero gain leaves only the offset
    '{16'sd1234,    8'h03, OP_SCALED, 8'd0,   -16'sd7,     1'b1, 1'b1},
    '{-16'sd1,      8'h04, OP_SCALED, 8'd1,   16'sd0,      1'b1, 1'b1},
    '{16'sh8000,    8'h05, OP_RAW,    8'd200, 16'sd0,      1'b1, 1'b1},
    '{16'sd321,     8'h06, OP_RAW,    8'd0,   16'sd0,      1'b1, 1'b1},
    '{16'sd1000,    8'h07, OP_DIFF,   8'd48,  16'sd0,      1'b1, 1'b1},
    '{-16'sd500,    8'h08, OP_MAX,    8'd16,  16'sd100,    1'b1, 1'b1},
    // positive and negative clamp of the scaled path
    '{16'sd30000,   8'h09, OP_SCALED, 8'd255, 16'sh7fff,   1'b1, 1'b1},
    '{-16'sd30000,  8'h0a, OP_SCALED, 8'd255, 16'sh8000,   1'b1, 1'b1},
    '{16'sd77,      8'h0b, OP_SCALED, 8'd16,  16'sd0,      1'b0, 1'b1},
    // subtraction clamps while the scaled value fits
    '{-16'sd20000,  8'h0c, OP_DIFF,   8'd0,   16'sd32000,  1'b1, 1'b1},
    '{16'sd20000,   8'h0d, OP_DIFF,   8'd0,   -16'sd32000, 1'b1, 1'b1},
    '{16'sd500,     8'h0e, OP_RAW,    8'd16,  16'sd0,      1'b1, 1'b0},
    '{16'sd30000,   8'h0f, OP_MAX,    8'd255, 16'sd0,      1'b1, 1'b1},
    '{-16'sd30000,  8'h10, OP_MAX,    8'd255, 16'sd0,      1'b1, 1'b1},
    '{16'sd25000,   8'h11, OP_DIFF,   8'd255, 16'sd0,      1'b1, 1'b1},
    '{16'sd4096,    8'h12, OP_SCALED, 8'd128, -16'sd16,    1'b1, 1'b1},
    '{16'sd0,       8'h13, OP_RAW,    8'd0,   16'sd0,      1'b0, 1'b1},
    '{-16'sd4096,   8'h14, OP_DIFF,   8'd255, 16'sd0,      1'b1, 1'b1},
    '{16'sd12345,   8'h15, OP_MAX,    8'd16,  -16'sd1,     1'b1, 1'b1},
    // shift of a negative product rounds down
    '{-16'sd7,      8'h16, OP_SCALED, 8'd3,   16'sd0,      1'b1, 1'b1},
    '{16'sd999,     8'h17, OP_RAW,    8'd8,   16'sd0,      1'b1, 1'b0},
    '{16'sh7fff,    8'h18, OP_DIFF,   8'd16,  16'sd0,      1'b1, 1'b1}
  };

  logic                  clk;
  logic                  nrst;
  logic                  ena;
  logic                  in_valid;
  sample_t               in_sample;
  tag_t                  in_tag;
  op_t                   in_op;
  logic [`SA_GAIN_W-1:0] gain;
  sample_t               offset;
  logic                  out_valid;
  sample_t               out_result;
  tag_t                  out_tag;
  logic                  out_sat;

  exp_t exp_q[$];
  int   edge_cnt = 0;
  logic edge_en  = 1'b0;

  sample_align_top i_dut (
    .clk        (clk),
    .nrst       (nrst),
    .ena        (ena),
    .in_valid   (in_valid),
    .in_sample  (in_sample),
    .in_tag     (in_tag),
    .in_op      (in_op),
    .gain       (gain),
    .offset     (offset),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_tag    (out_tag),
    .out_sat    (out_sat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // reference model and compare tasks
  // ----------------------------------------
  function automatic int clamp16(int v);
    if (v > SMAX) return SMAX;
    if (v < SMIN) return SMIN;
    return v;
  endfunction

  function automatic exp_t model_sample(sample_t s, logic [`SA_GAIN_W-1:0] g,
                                        sample_t off, op_t op, tag_t tag);
    int   sc;
    int   raw;
    int   d;
    logic sc_sat;
    exp_t e;
    // signed sample times unsigned gain, floor shift, then offset
    sc     = ((int'(s) * int'(g)) >>> `SA_SHIFT) + int'(off);
    sc_sat = (sc != clamp16(sc));
    sc     = clamp16(sc);
    raw    = int'(s);
    e.tag  = tag;
    case (op)
      OP_SCALED: begin
        e.result = sample_t'(sc);
        e.sat    = sc_sat;
      end
      OP_RAW: begin
        e.result = s;
        e.sat    = 1'b0;
      end
      OP_DIFF: begin
        d        = sc - raw;
        e.result = sample_t'(clamp16(d));
        e.sat    = sc_sat || (d != clamp16(d));
      end
      default: begin
        e.result = sample_t'((sc > raw) ? sc : raw);
        e.sat    = sc_sat;
      end
    endcase
    return e;
  endfunction

  task automatic fail_run();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_result(string name, sample_t exp, sample_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_tag(string name, tag_t exp, tag_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected 0x%02h got 0x%02h", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_sat(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_latency(string name, int exp, int act);
    if (act != exp) begin
      $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, act);
      fail_run();
    end
  endtask

  // ----------------------------------------
  // monitor
  // ----------------------------------------
  // model runs on each sample accepted at a rising edge
  always @(posedge clk) begin
    edge_en = nrst && ena;
    if (edge_en) begin
      edge_cnt = edge_cnt + 1;
      if (in_valid) begin
        exp_q.push_back(model_sample(in_sample, gain, offset, in_op, in_tag));
        exp_q[$].acc_edge = edge_cnt;
      end
    end
  end

  // outputs of an enabled edge are compared half a cycle later
  always @(negedge clk) begin
    exp_t e;
    if (edge_en) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("out_valid is high at %0t with no sample pending", $time);
          fail_run();
        end
        e = exp_q.pop_front();
        check_result("out_result", e.result, out_result);
        check_tag("out_tag", e.tag, out_tag);
        check_sat("out_sat", e.sat, out_sat);
        // the accepting edge counts as the first of the latency edges
        check_latency("latency", LATENCY, edge_cnt - e.acc_edge + 1);
      end else begin
        // empty slot gives zero outputs
        check_result("out_result", '0, out_result);
        check_tag("out_tag", '0, out_tag);
        check_sat("out_sat", 1'b0, out_sat);
        if (exp_q.size() != 0 && edge_cnt - exp_q[0].acc_edge + 1 >= LATENCY) begin
          $display("output for tag 0x%02h missing at %0t", exp_q[0].tag, $time);
          fail_run();
        end
      end
    end
  end

  // ----------------------------------------
  // drivers
  // ----------------------------------------
  task automatic drive_row(row_t r);
    @(posedge clk);
    #1;
    ena       = r.ena;
    in_valid  = r.valid;
    in_sample = r.sample;
    in_tag    = r.tag;
    in_op     = r.op;
    gain      = r.gain;
    offset    = r.offset;
  endtask

  // random data under ena low must not move the pipeline
  task automatic drive_gap();
    @(posedge clk);
    #1;
    ena       = 1'b0;
    in_valid  = 1'($urandom_range(0, 1));
    in_sample = sample_t'($urandom);
    in_tag    = tag_t'($urandom);
    in_op     = op_t'($urandom_range(0, 3));
    gain      = 8'($urandom);
    offset    = sample_t'($urandom);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    ena      = 1'b1;
    in_valid = 1'b0;
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    #((N_ROWS + 20) * 4 * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    fail_run();
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int gaps;
    void'($urandom(32'hcff7a673));
    nrst      = 1'b0;
    ena       = 1'b0;
    in_valid  = 1'b0;
    in_sample = '0;
    in_tag    = '0;
    in_op     = OP_SCALED;
    gain      = '0;
    offset    = '0;
    repeat (10) @(posedge clk);
    #1;
    nrst = 1'b1;
    // outputs must be clear straight after reset
    @(negedge clk);
    check_valid("out_valid", 1'b0, out_valid);
    check_sat("out_sat", 1'b0, out_sat);
    check_result("out_result", '0, out_result);
    for (int i = 0; i < N_ROWS; i++) begin
      drive_row(ROWS[i]);
      if (i >= BURST_ROWS) begin
        gaps = $urandom_range(0, 2);
        repeat (gaps) drive_gap();
      end
    end
    // flush the last samples through the pipeline
    repeat (LATENCY + 1) drive_idle();
    @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d expected results never appeared", exp_q.size());
      fail_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* logic/delay_line.sv */
// fixed register delay with clock enable
// LENGTH 0 is a plain wire, no register and no reset effect
// all stages clear on synchronous reset and advance only with ena
// not meant as a clock domain synchronizer here

`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int LENGTH = 2,  // number of register stages
  parameter int WIDTH  = 1   // bits per stage
) (
  input  logic             clk,
  input  logic             nrst,
  input  logic             ena,
  input  logic [WIDTH-1:0] in,
  output logic [WIDTH-1:0] out
);

  generate
    if (LENGTH == 0) begin : g_wire

      // pass straight through
      assign out = in;

    end else if (LENGTH == 1) begin : g_single

      logic [WIDTH-1:0] data;

      // single stage
      always_ff @(posedge clk) begin
        if (!nrst) begin
          data <= '0;
        end else if (ena) begin
          data <= in;
        end
      end

      assign out = data;

    end else begin : g_chain

      // data[1] is the newest entry, data[LENGTH] the oldest
      logic [LENGTH:1][WIDTH-1:0] data;

      always_ff @(posedge clk) begin
        if (!nrst) begin
          data <= '0;
        end else if (ena) begin
          // shift by one stage, new sample enters at index 1
          data <= {data[LENGTH-1:1], in};
        end
      end

      assign out = data[LENGTH];

    end
  endgenerate

endmodule

`default_nettype wire

/* logic/result_combine.sv */
// merges the scaled path and the delayed raw path, one registered stage
// both inputs must belong to the same sample slot
// invalid slots give zero result, zero tag and sat low
// the difference has its own clamp, its overflow also raises out_sat

`timescale 1ns/1ps
`default_nettype none

`include "sa_defines.svh"

module result_combine
  import sa_pkg::*;
(
  input  logic    clk,
  input  logic    nrst,
  input  logic    ena,
  input  sample_t scaled,
  input  logic    scaled_sat,
  input  logic    raw_valid,
  input  op_t     raw_op,
  input  tag_t    raw_tag,
  input  sample_t raw_sample,
  output logic    out_valid,
  output sample_t out_result,
  output tag_t    out_tag,
  output logic    out_sat
);

  // ---------------------------------------
  // difference with clamp
  // ---------------------------------------
  logic signed [`SA_SAMPLE_W:0] diff_wide;
  logic                         diff_ovf;
  sample_t                      diff;

  always_comb begin
    // one extra bit holds any difference of two samples
    diff_wide = scaled - raw_sample;
    diff_ovf  = diff_wide[`SA_SAMPLE_W] != diff_wide[`SA_SAMPLE_W-1];
    if (!diff_ovf) begin
      diff = diff_wide[`SA_SAMPLE_W-1:0];
    end else if (!diff_wide[`SA_SAMPLE_W]) begin
      diff = {1'b0, {(`SA_SAMPLE_W-1){1'b1}}};
    end else begin
      diff = {1'b1, {(`SA_SAMPLE_W-1){1'b0}}};
    end
  end

  // ---------------------------------------
  // opcode decode
  // ---------------------------------------
  sample_t res_next;
  logic    sat_next;

  always_comb begin
    case (raw_op)
      OP_SCALED: begin
        res_next = scaled;
        sat_next = scaled_sat;
      end
      OP_RAW: begin
        // raw sample never saturates
        res_next = raw_sample;
        sat_next = 1'b0;
      end
      OP_DIFF: begin
        res_next = diff;
        sat_next = scaled_sat || diff_ovf;
      end
      OP_MAX: begin
        // signed compare, both operands are sample_t
        res_next = (scaled > raw_sample) ? scaled : raw_sample;
        sat_next = scaled_sat;
      end
      default: begin
        res_next = scaled;
        sat_next = scaled_sat;
      end
    endcase
  end

  // output register, zeroed for empty slots
  always_ff @(posedge clk) begin
    if (!nrst) begin
      out_valid  <= 1'b0;
      out_result <= '0;
      out_tag    <= '0;
      out_sat    <= 1'b0;
    end else if (ena) begin
      out_valid  <= raw_valid;
      out_result <= raw_valid ? res_next : '0;
      out_tag    <= raw_valid ? raw_tag : '0;
      out_sat    <= raw_valid && sat_next;
    end
  end

endmodule

`default_nettype wire

/* logic/sa_defines.svh */
// widths and depths shared by the sample alignment design
// SA_PIPE_DEPTH must match the register count of scale_pipe,
// the raw path delay is sized from it
// SA_SHIFT is an arithmetic right shift, so negative products round
// toward minus infinity

`ifndef SA_DEFINES_SVH
`define SA_DEFINES_SVH

// sample and result width, signed
`define SA_SAMPLE_W 16

// sideband tag, carried unchanged
`define SA_TAG_W 8

// gain is unsigned
`define SA_GAIN_W 8

// post-multiply scaling
`define SA_SHIFT 4

// scale_pipe latency in enabled cycles
`define SA_PIPE_DEPTH 3

`endif

/* logic/sa_pkg.sv */
// types for the sample alignment design
// widths come from sa_defines.svh
// op_t encoding is fixed at two bits, new opcodes need a wider enum

`default_nettype none

`include "sa_defines.svh"

package sa_pkg;

  // ---------------------------------------
  // per-sample opcode
  // ---------------------------------------
  typedef enum logic [1:0] {
    OP_SCALED = 2'd0,  // scaled value
    OP_RAW    = 2'd1,  // raw sample, untouched
    OP_DIFF   = 2'd2,  // scaled minus raw, clamped
    OP_MAX    = 2'd3   // signed max of scaled and raw
  } op_t;

  // ---------------------------------------
  // data types
  // ---------------------------------------
  // two's complement sample
  typedef logic signed [`SA_SAMPLE_W-1:0] sample_t;

  // opaque tag, never interpreted
  typedef logic [`SA_TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

/* logic/sample_align_top.sv */
// sample alignment top: scaled path and raw delay path side by side
// latency from accepted input to outputs is SA_PIPE_DEPTH + 1 enabled cycles
// ena is the only flow control, there is no back-pressure
// gain and offset are sampled together with each sample

`timescale 1ns/1ps
`default_nettype none

`include "sa_defines.svh"

module sample_align_top
  import sa_pkg::*;
(
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  ena,
  input  logic                  in_valid,
  input  sample_t               in_sample,
  input  tag_t                  in_tag,
  input  op_t                   in_op,
  input  logic [`SA_GAIN_W-1:0] gain,
  input  sample_t               offset,
  output logic                  out_valid,
  output sample_t               out_result,
  output tag_t                  out_tag,
  output logic                  out_sat
);

  // raw bundle is valid, op, tag, sample from msb down
  localparam int BUNDLE_W = 1 + $bits(op_t) + `SA_TAG_W + `SA_SAMPLE_W;

  // ---------------------------------------
  // path a: scaling pipeline
  // ---------------------------------------
  sample_t scaled;
  logic    scaled_sat;

  scale_pipe i_scale (
    .clk    (clk),
    .nrst   (nrst),
    .ena    (ena),
    .sample (in_sample),
    .gain   (gain),
    .offset (offset),
    .scaled (scaled),
    .sat    (scaled_sat)
  );

  // ---------------------------------------
  // path b: raw delay, same depth as path a
  // ---------------------------------------
  wire                 dly_valid;
  wire [$bits(op_t)-1:0] dly_op;
  wire tag_t           dly_tag;
  wire sample_t        dly_sample;

  delay_line #(
    .LENGTH (`SA_PIPE_DEPTH),
    .WIDTH  (BUNDLE_W)
  ) i_delay (
    .clk  (clk),
    .nrst (nrst),
    .ena  (ena),
    .in   ({in_valid, in_op, in_tag, in_sample}),
    .out  ({dly_valid, dly_op, dly_tag, dly_sample})
  );

  // ---------------------------------------
  // merge stage
  // ---------------------------------------
  result_combine i_combine (
    .clk        (clk),
    .nrst       (nrst),
    .ena        (ena),
    .scaled     (scaled),
    .scaled_sat (scaled_sat),
    .raw_valid  (dly_valid),
    .raw_op     (op_t'(dly_op)),
    .raw_tag    (dly_tag),
    .raw_sample (dly_sample),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_tag    (out_tag),
    .out_sat    (out_sat)
  );

endmodule

`default_nettype wire

/* logic/scale_pipe.sv */
// three stage scaling pipeline: sample * gain >>> SA_SHIFT + offset
// gain is unsigned, sample and offset are signed
// result is clamped to the sample range, sat flags each clamp
// latency is exactly 3 enabled cycles, ena low freezes all stages

`timescale 1ns/1ps
`default_nettype none

`include "sa_defines.svh"

module scale_pipe
  import sa_pkg::*;
(
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  ena,
  input  sample_t               sample,
  input  logic [`SA_GAIN_W-1:0] gain,
  input  sample_t               offset,
  output sample_t               scaled,
  output logic                  sat
);

  // product keeps a spare bit for the zero-extended gain
  localparam int PROD_W = `SA_SAMPLE_W + `SA_GAIN_W + 1;
  // one more bit so the offset add cannot wrap
  localparam int SUM_W  = PROD_W + 1;

  // ---------------------------------------
  // stage 1: capture operands
  // ---------------------------------------
  sample_t               s1_sample;
  logic [`SA_GAIN_W-1:0] s1_gain;
  sample_t               s1_offset;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      s1_sample <= '0;
      s1_gain   <= '0;
      s1_offset <= '0;
    end else if (ena) begin
      s1_sample <= sample;
      s1_gain   <= gain;
      s1_offset <= offset;
    end
  end

  // ---------------------------------------
  // stage 2: widened signed multiply
  // ---------------------------------------
  logic signed [PROD_W-1:0] s2_prod;
  sample_t                  s2_offset;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      s2_prod   <= '0;
      s2_offset <= '0;
    end else if (ena) begin
      // gain gets a zero msb so it stays positive in the signed multiply
      s2_prod   <= s1_sample * $signed({1'b0, s1_gain});
      s2_offset <= s1_offset;
    end
  end

  // ---------------------------------------
  // stage 3: shift, offset, clamp
  // ---------------------------------------
  logic signed [PROD_W-1:0] shifted;
  logic signed [SUM_W-1:0]  sum;
  logic [SUM_W-`SA_SAMPLE_W:0] sum_top;
  logic                     fits;
  sample_t                  clamped;

  always_comb begin
    shifted = s2_prod >>> `SA_SHIFT;
    // offset is sign extended by the signed context
    sum     = shifted + s2_offset;
    // value fits when all bits from the sample msb upward agree
    sum_top = sum[SUM_W-1:`SA_SAMPLE_W-1];
    fits    = (&sum_top) || !(|sum_top);
    if (fits) begin
      clamped = sum[`SA_SAMPLE_W-1:0];
    end else if (!sum[SUM_W-1]) begin
      // positive overflow, largest sample
      clamped = {1'b0, {(`SA_SAMPLE_W-1){1'b1}}};
    end else begin
      // negative overflow, smallest sample
      clamped = {1'b1, {(`SA_SAMPLE_W-1){1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      scaled <= '0;
      sat    <= 1'b0;
    end else if (ena) begin
      scaled <= clamped;
      sat    <= !fits;
    end
  end

endmodule

`default_nettype wire

/* sample_align.f */
+incdir+logic
logic/sa_pkg.sv
logic/delay_line.sv
logic/scale_pipe.sv
logic/result_combine.sv
logic/sample_align_top.sv
dv/sa_props.sv
dv/sa_tb.sv
